// File: hdl/axil_pkg.sv
// AXI4-Lite channel payloads for a 32-bit address and data target
// valid and ready travel beside these structs as plain wires
// prot is carried on aw and ar but the memory ignores it
package axil_pkg;

  // response codes, only the two that the target can return
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // write address channel, 35 bits
  typedef struct packed {
    logic [31:0] addr; // byte address
    logic [2:0]  prot; // unused by the memory
  } axil_aw_t;

  // write data channel, 36 bits
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb; // one bit per byte lane
  } axil_w_t;

  // read address channel, 35 bits
  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  prot;
  } axil_ar_t;

  // write response, 2 bits
  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  // read data and response, 34 bits
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } axil_r_t;

endpackage

// File: hdl/tcdm_pkg.sv
// bank request and response records of the TCDM
// wen follows the bank convention: high means read, low means write
// bank is sized for up to 16 banks, row for up to 65536 words per bank
package tcdm_pkg;

  // id tells the collector which AXI channel owns the response
  localparam logic ID_WRITE = 1'b0;
  localparam logic ID_READ  = 1'b1;

  // request from the decoder to the bank array, 60 bits
  typedef struct packed {
    logic        req;  // one-cycle pulse per transaction
    logic        wen;  // 1 read, 0 write
    logic        err;  // out of range, no memory access
    logic [3:0]  bank; // only the low log2(NbBanks) bits are meaningful
    logic [15:0] row;  // word index inside the bank
    logic [31:0] data; // write data
    logic [3:0]  be;   // byte enables for writes
    logic        id;   // ID_WRITE or ID_READ
  } tcdm_req_t;

  // response from the bank array, 35 bits
  typedef struct packed {
    logic        r_valid; // one cycle after the granted request
    logic        r_err;   // echo of the request err
    logic        r_id;    // echo of the request id
    logic [31:0] r_data;  // read data, undefined for writes
  } tcdm_rsp_t;

  // the decoder drives req only for accepted beats
  // the collector never sees two responses in flight
  // the array never stalls, so a request is answered the next cycle
  // all three blocks share these two records through this package
  // field widths are fixed, parameters only narrow what is decoded

endpackage

// File: hdl/tcdm_req_decode.sv
// AXI4-Lite front end of the TCDM, one transaction in flight at a time
// ready is combinational on valid and busy_i, so the host sees it in the accept cycle
// writes need aw and w together and win over a pending read
// NbBanks and BankWords must be powers of two, each at least 2
// addresses at or above 4*NbBanks*BankWords are flagged, not wrapped
`timescale 1ns/1ns

module tcdm_req_decode import axil_pkg::*; import tcdm_pkg::*; #(
  parameter int unsigned NbBanks   = 4,
  parameter int unsigned BankWords = 256
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  axil_aw_t  aw_i,
  input  axil_w_t   w_i,
  input  axil_ar_t  ar_i,
  input  logic      aw_valid_i,
  input  logic      w_valid_i,
  input  logic      ar_valid_i,
  output logic      aw_ready_o,
  output logic      w_ready_o,
  output logic      ar_ready_o,
  input  logic      busy_i,
  output tcdm_req_t bank_req_o
);

  localparam int unsigned BankBits = $clog2(NbBanks);
  localparam int unsigned RowBits  = $clog2(BankWords);
  localparam int unsigned MemBytes = 4 * NbBanks * BankWords; // first illegal byte address

  logic        wr_ok;     // both write channels presented
  logic        wr_accept; // write handshake this cycle
  logic        rd_accept; // read handshake this cycle
  logic [31:0] addr;      // address of the winning channel
  tcdm_req_t   req_d;
  tcdm_req_t   pay_q;     // request payload, held until the next accept
  logic        req_q;     // issue pulse, cycle after accept

  assign wr_ok     = aw_valid_i & w_valid_i;
  assign wr_accept = wr_ok & ~busy_i;
  assign rd_accept = ar_valid_i & ~wr_ok & ~busy_i; // write priority

  assign aw_ready_o = wr_accept; // aw and w always move together
  assign w_ready_o  = wr_accept;
  assign ar_ready_o = rd_accept;

  assign addr = wr_ok ? aw_i.addr : ar_i.addr;

  // build the bank request from whichever channel wins
  always_comb begin
    req_d      = '0;
    req_d.wen  = ~wr_ok;                          // high means read
    req_d.err  = (addr >= MemBytes);
    req_d.bank = 4'(addr[2 +: BankBits]);         // word interleaving
    req_d.row  = 16'(addr[2 + BankBits +: RowBits]);
    req_d.data = w_i.data;
    req_d.be   = wr_ok ? w_i.strb : 4'b0000;      // reads touch no byte lane
    req_d.id   = wr_ok ? ID_WRITE : ID_READ;
  end

  // issue pulse, high for exactly one cycle after the handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else begin
      req_q <= wr_accept | rd_accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_accept | rd_accept) begin
      pay_q <= req_d; // capture only on accept
    end
  end

  // the registered payload with the control bit from the reset domain
  always_comb begin
    bank_req_o     = pay_q;
    bank_req_o.req = req_q;
  end

endmodule

// File: hdl/tcdm_bank_array.sv
// word-interleaved array of NbBanks single-port banks, BankWords words each
// banks power up all ones, so an unwritten word reads 32'hffffffff
// grant is tied high, every request is served the cycle it arrives
// response valid and id follow the request by one cycle, for reads and writes
// requests with err set reach no bank but still get a response
`timescale 1ns/1ns

module tcdm_bank_array import tcdm_pkg::*; #(
  parameter int unsigned NbBanks   = 4,
  parameter int unsigned BankWords = 256
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  tcdm_req_t bank_req_i,
  output tcdm_rsp_t bank_rsp_o
);

  localparam int unsigned BankBits = $clog2(NbBanks);
  localparam int unsigned RowBits  = $clog2(BankWords);

  logic                gnt;                // always granted
  logic [31:0]         rdata_q [NbBanks];  // per-bank read port
  logic [BankBits-1:0] bank_q;             // bank addressed last cycle
  logic                r_valid_q;
  logic                r_id_q;
  logic                r_err_q;

  assign gnt = 1'b1;

  for (genvar b = 0; b < NbBanks; b++) begin : gen_bank
    logic [31:0] mem_q [BankWords] = '{default: '1}; // power-up state of the SRAM
    logic        sel;

    // only the addressed bank sees the request, and only when in range
    assign sel = bank_req_i.req & gnt & ~bank_req_i.err &
                 (bank_req_i.bank[BankBits-1:0] == BankBits'(b));

    always_ff @(posedge clk_i) begin
      if (sel && !bank_req_i.wen) begin
        for (int j = 0; j < 4; j++) begin
          if (bank_req_i.be[j]) begin
            mem_q[bank_req_i.row[RowBits-1:0]][8*j +: 8] <= bank_req_i.data[8*j +: 8];
          end
        end
      end
      if (sel && bank_req_i.wen) begin
        rdata_q[b] <= mem_q[bank_req_i.row[RowBits-1:0]]; // 1-cycle read latency
      end
    end
  end

  // valid and id, reset like any handshake state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
      r_id_q    <= 1'b0;
    end else begin
      r_valid_q <= bank_req_i.req & gnt; // writes answer too
      r_id_q    <= bank_req_i.id;        // echo, one cycle late
    end
  end

  always_ff @(posedge clk_i) begin
    if (bank_req_i.req) begin
      bank_q  <= bank_req_i.bank[BankBits-1:0]; // steers the read mux
      r_err_q <= bank_req_i.err;
    end
  end

  always_comb begin
    bank_rsp_o.r_valid = r_valid_q;
    bank_rsp_o.r_err   = r_err_q;
    bank_rsp_o.r_id    = r_id_q;
    bank_rsp_o.r_data  = rdata_q[bank_q]; // stale for writes, nobody reads it
  end

endmodule

// File: hdl/tcdm_resp_collect.sv
// turns the bank response into an AXI4-Lite B or R beat
// the beat is registered and held until the matching ready
// busy covers issue to completion, so only one transaction is ever in flight
// reads that hit an out-of-range address return zero data with SLVERR
`timescale 1ns/1ns

module tcdm_resp_collect import axil_pkg::*; import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      issue_i,     // request pulse from the decoder
  input  tcdm_rsp_t bank_rsp_i,
  output axil_b_t   b_o,
  output logic      b_valid_o,
  input  logic      b_ready_i,
  output axil_r_t   r_o,
  output logic      r_valid_o,
  input  logic      r_ready_i,
  output logic      busy_o
);

  logic    b_valid_q;
  logic    r_valid_q;
  logic    busy_q;    // set after issue, cleared by the transfer
  logic    done;      // B or R beat transfers this cycle
  logic    rsp_wr;    // bank answer for the write channel
  logic    rsp_rd;
  axil_b_t b_q;
  axil_r_t r_q;

  assign rsp_wr = bank_rsp_i.r_valid & (bank_rsp_i.r_id == ID_WRITE);
  assign rsp_rd = bank_rsp_i.r_valid & (bank_rsp_i.r_id == ID_READ);
  assign done   = (b_valid_q & b_ready_i) | (r_valid_q & r_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
      busy_q    <= 1'b0;
    end else begin
      if (issue_i) begin
        busy_q <= 1'b1;
      end else if (done) begin
        busy_q <= 1'b0;
      end
      if (rsp_wr) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0; // beat taken
      end
      if (rsp_rd) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // payload captured once per response, then frozen while valid waits
  always_ff @(posedge clk_i) begin
    if (rsp_wr) begin
      b_q.resp <= bank_rsp_i.r_err ? RESP_SLVERR : RESP_OKAY;
    end
    if (rsp_rd) begin
      r_q.data <= bank_rsp_i.r_err ? 32'h0 : bank_rsp_i.r_data; // no data past the end
      r_q.resp <= bank_rsp_i.r_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign b_o       = b_q;
  assign b_valid_o = b_valid_q;
  assign r_o       = r_q;
  assign r_valid_o = r_valid_q;
  assign busy_o    = issue_i | busy_q; // high already in the issue cycle

endmodule

// File: hdl/axil_tcdm_top.sv
// AXI4-Lite target in front of a banked TCDM, one transaction at a time
// a handshake at cycle 0 gives its B or R beat at cycle 3 at the earliest
// NbBanks and BankWords must be powers of two, each at least 2
// memory spans 4*NbBanks*BankWords bytes from address 0, above that SLVERR
// prot on aw and ar is accepted and ignored
`timescale 1ns/1ns

module axil_tcdm_top import axil_pkg::*; import tcdm_pkg::*; #(
  parameter int unsigned NbBanks   = 4,
  parameter int unsigned BankWords = 256
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  // write address
  input  axil_aw_t aw_i,
  input  logic     aw_valid_i,
  output logic     aw_ready_o,
  // write data
  input  axil_w_t  w_i,
  input  logic     w_valid_i,
  output logic     w_ready_o,
  // read address
  input  axil_ar_t ar_i,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,
  // write response
  output axil_b_t  b_o,
  output logic     b_valid_o,
  input  logic     b_ready_i,
  // read data
  output axil_r_t  r_o,
  output logic     r_valid_o,
  input  logic     r_ready_i
);

  tcdm_req_t bank_req; // decoder to banks
  tcdm_rsp_t bank_rsp; // banks to collector
  logic      busy;     // collector back to decoder

  tcdm_req_decode #(
    .NbBanks  (NbBanks),
    .BankWords(BankWords)
  ) i_decode (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .aw_i      (aw_i),
    .w_i       (w_i),
    .ar_i      (ar_i),
    .aw_valid_i(aw_valid_i),
    .w_valid_i (w_valid_i),
    .ar_valid_i(ar_valid_i),
    .aw_ready_o(aw_ready_o),
    .w_ready_o (w_ready_o),
    .ar_ready_o(ar_ready_o),
    .busy_i    (busy),
    .bank_req_o(bank_req)
  );

  tcdm_bank_array #(
    .NbBanks  (NbBanks),
    .BankWords(BankWords)
  ) i_banks (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .bank_req_i(bank_req),
    .bank_rsp_o(bank_rsp)
  );

  tcdm_resp_collect i_collect (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .issue_i   (bank_req.req), // starts busy in the issue cycle
    .bank_rsp_i(bank_rsp),
    .b_o       (b_o),
    .b_valid_o (b_valid_o),
    .b_ready_i (b_ready_i),
    .r_o       (r_o),
    .r_valid_o (r_valid_o),
    .r_ready_i (r_ready_i),
    .busy_o    (busy)
  );

endmodule

// File: testbench/axil_tcdm_chk.sv
// protocol assertions on the AXI4-Lite side of the TCDM top level
// bound into every axil_tcdm_top instance, all checks are off while in reset
`timescale 1ns/1ns

module axil_tcdm_chk import axil_pkg::*; (
  input logic    clk_i,
  input logic    rst_ni,
  input logic    aw_ready_i,
  input logic    w_ready_i,
  input axil_b_t b_i,
  input logic    b_valid_i,
  input logic    b_ready_i,
  input axil_r_t r_i,
  input logic    r_valid_i,
  input logic    r_ready_i
);

  // a waiting B beat keeps its valid and its code until bready
  b_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_i))
    else $error("B beat dropped or changed before bready");

  // same rule on R, data included
  r_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else $error("R beat dropped or changed before rready");

  aw_w_ready_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_ready_i == w_ready_i)
    else $error("awready and wready differ");

  // one transaction in flight, so never two beats at once
  one_beat_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(b_valid_i && r_valid_i))
    else $error("B and R valid in the same cycle");

endmodule

bind axil_tcdm_top axil_tcdm_chk chk_i (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .aw_ready_i(aw_ready_o),
  .w_ready_i (w_ready_o),
  .b_i       (b_o),
  .b_valid_i (b_valid_o),
  .b_ready_i (b_ready_i),
  .r_i       (r_o),
  .r_valid_i (r_valid_o),
  .r_ready_i (r_ready_i)
);

// File: testbench/axil_tcdm_tb.sv
// testbench for the AXI4-Lite TCDM with 4 banks of 64 words, so 1024 bytes of memory
// expected beats come from a byte shadow memory that powers up all ones
// only one transaction is in flight at a time, as the DUT allows
// a wait that times out marks the run failed and makes all later waits return at once
`timescale 1ns/1ns

module axil_tcdm_tb import axil_pkg::*; ();

  localparam int unsigned NbBanks   = 4;
  localparam int unsigned BankWords = 64;
  localparam int unsigned MemBytes  = 4 * NbBanks * BankWords;
  localparam int unsigned AW        = $clog2(MemBytes); // shadow index width
  localparam int          TIMEOUT   = 200;              // cycles per wait
  localparam logic [31:0] SEED      = 32'd20122;

  logic     clk_i;
  logic     rst_ni;
  axil_aw_t aw;
  logic     aw_valid;
  logic     aw_ready;
  axil_w_t  w;
  logic     w_valid;
  logic     w_ready;
  axil_ar_t ar;
  logic     ar_valid;
  logic     ar_ready;
  axil_b_t  b;
  logic     b_valid;
  logic     b_ready = 1'b1;
  axil_r_t  r;
  logic     r_valid;
  logic     r_ready = 1'b1;

  logic [7:0]  shadow [MemBytes]; // reference memory, one entry per byte
  logic [1:0]  exp_b_q [$];       // expected B codes, in issue order
  axil_r_t     exp_r_q [$];
  logic [31:0] seed;
  logic [31:0] bp_state;          // own LCG state for back-pressure
  bit          stall_mode;
  bit          timed_out;
  int          errors;
  int          err_base;
  int          checks;
  bit          b_hold;            // B was waiting at the last falling edge
  bit          r_hold;
  axil_b_t     b_prev;
  axil_r_t     r_prev;

  axil_tcdm_top #(
    .NbBanks  (NbBanks),
    .BankWords(BankWords)
  ) dut_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .aw_i      (aw),
    .aw_valid_i(aw_valid),
    .aw_ready_o(aw_ready),
    .w_i       (w),
    .w_valid_i (w_valid),
    .w_ready_o (w_ready),
    .ar_i      (ar),
    .ar_valid_i(ar_valid),
    .ar_ready_o(ar_ready),
    .b_o       (b),
    .b_valid_o (b_valid),
    .b_ready_i (b_ready),
    .r_o       (r),
    .r_valid_o (r_valid),
    .r_ready_i (r_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i; // 20 ns period
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // expected R beat: shadow bytes in range, zero data with SLVERR above it
  function automatic axil_r_t ref_read(input logic [31:0] addr);
    axil_r_t exp;
    exp = '0;
    if (addr >= MemBytes) begin
      exp.resp = RESP_SLVERR;
    end else begin
      for (int j = 0; j < 4; j++) begin
        exp.data[8*j +: 8] = shadow[{addr[AW-1:2], 2'b00} + AW'(j)];
      end
      exp.resp = RESP_OKAY;
    end
    return exp;
  endfunction

  function automatic logic [1:0] ref_bresp(input logic [31:0] addr);
    return (addr >= MemBytes) ? RESP_SLVERR : RESP_OKAY;
  endfunction

  task automatic shadow_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
    if (addr < MemBytes) begin // out-of-range writes change nothing
      for (int j = 0; j < 4; j++) begin
        if (strb[j]) shadow[{addr[AW-1:2], 2'b00} + AW'(j)] = data[8*j +: 8];
      end
    end
  endtask

  function automatic void report_mismatch(input string name, input logic [31:0] got,
                                          input logic [31:0] exp);
    $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    errors++;
  endfunction

  // waits at falling edges until the channel is ready, the handshake is the next rise
  task automatic wait_accept(input bit is_read);
    int n;
    n = 0;
    if (!timed_out) begin
      @(negedge clk_i);
      while (!(is_read ? ar_ready : (aw_ready && w_ready)) && n < TIMEOUT) begin
        @(negedge clk_i);
        n++;
      end
      if (n >= TIMEOUT) begin
        $display("timeout: %s was never accepted", is_read ? "AR" : "AW and W");
        timed_out = 1'b1;
        errors++;
      end
    end
  endtask

  task automatic accept_write();
    wait_accept(1'b0);
    if (!timed_out) begin
      exp_b_q.push_back(ref_bresp(aw.addr));
      shadow_write(aw.addr, w.data, w.strb);
    end
    @(posedge clk_i);
    #2;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
  endtask

  task automatic accept_read();
    wait_accept(1'b1);
    if (!timed_out) exp_r_q.push_back(ref_read(ar.addr)); // after any earlier write
    @(posedge clk_i);
    #2;
    ar_valid = 1'b0;
  endtask

  task automatic send_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    aw.addr  = addr;
    aw.prot  = 3'b000;
    w.data   = data;
    w.strb   = strb;
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    accept_write();
  endtask

  task automatic send_read(input logic [31:0] addr);
    ar.addr  = addr;
    ar.prot  = 3'b000;
    ar_valid = 1'b1;
    accept_read();
  endtask

  // all expected beats seen, the last one transfers on the next rise
  task automatic wait_done();
    int n;
    n = 0;
    while (!timed_out && (exp_b_q.size() != 0 || exp_r_q.size() != 0)) begin
      @(negedge clk_i);
      n++;
      if (n >= TIMEOUT) begin
        $display("timeout: a B or R beat never completed");
        timed_out = 1'b1;
        errors++;
      end
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic close_test(input int num, input string name);
    if (errors != err_base) $display("test %0d %s: failed", num, name);
    else if (timed_out) $display("test %0d %s: skipped after a timeout", num, name);
    else $display("test %0d %s: ok", num, name);
    err_base = errors;
  endtask

  // back-pressure, each ready high one cycle in four while stalling
  always @(posedge clk_i) begin
    #2;
    bp_state = lcg(bp_state);
    b_ready  = stall_mode ? (bp_state[22:21] == 2'b00) : 1'b1;
    r_ready  = stall_mode ? (bp_state[26:25] == 2'b00) : 1'b1;
  end

  // compare process, samples at the falling edge where everything is settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (b_hold && (!b_valid || b !== b_prev)) begin
        $display("B beat changed at %0t ns while bready was low", $time);
        errors++;
      end
      if (r_hold && (!r_valid || r !== r_prev)) begin
        $display("R beat changed at %0t ns while rready was low", $time);
        errors++;
      end
      if ((b_valid || r_valid) && (aw_ready || ar_ready)) begin
        $display("request accepted at %0t ns while a response was pending", $time);
        errors++;
      end
      if (ar_ready && aw_valid && w_valid) begin
        $display("read accepted at %0t ns although a write was presented", $time);
        errors++;
      end
      if (b_valid && b_ready) begin
        if (exp_b_q.size() == 0) begin
          $display("unexpected B beat at %0t ns", $time);
          errors++;
        end else begin
          checks++;
          if (b.resp !== exp_b_q[0]) report_mismatch("b.resp", 32'(b.resp), 32'(exp_b_q[0]));
          void'(exp_b_q.pop_front());
        end
      end
      if (r_valid && r_ready) begin
        if (exp_r_q.size() == 0) begin
          $display("unexpected R beat at %0t ns", $time);
          errors++;
        end else begin
          checks++;
          if (r.data !== exp_r_q[0].data) report_mismatch("r.data", r.data, exp_r_q[0].data);
          if (r.resp !== exp_r_q[0].resp) report_mismatch("r.resp", 32'(r.resp),
                                                          32'(exp_r_q[0].resp));
          void'(exp_r_q.pop_front());
        end
      end
    end
    b_hold = rst_ni && b_valid && !b_ready;
    r_hold = rst_ni && r_valid && !r_ready;
    b_prev = b;
    r_prev = r;
  end

  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    rst_ni     = 1'b0;
    aw         = '0;
    w          = '0;
    ar         = '0;
    aw_valid   = 1'b0;
    w_valid    = 1'b0;
    ar_valid   = 1'b0;
    seed       = SEED;
    bp_state   = SEED;
    stall_mode = 1'b0;
    timed_out  = 1'b0;
    errors     = 0;
    err_base   = 0;
    checks     = 0;
    for (int i = 0; i < MemBytes; i++) shadow[i] = 8'hff;
    repeat (8) @(posedge clk_i);
    #2;
    if (aw_ready || w_ready || ar_ready || b_valid || r_valid) begin
      $display("handshake outputs not low during reset");
      errors++;
    end
    rst_ni = 1'b1;
    repeat (2) @(posedge clk_i);
    #2;

    send_read(32'h0000_0040); // never written
    wait_done();
    close_test(1, "untouched word reads all ones");

    for (int i = 0; i < 8; i++) begin // consecutive words walk all banks twice
      seed = lcg(seed);
      send_write(32'h100 + 32'(i) * 32'd4, seed, 4'b1111);
      wait_done();
    end
    for (int i = 0; i < 8; i++) begin
      send_read(32'h100 + 32'(i) * 32'd4);
      wait_done();
    end
    close_test(2, "full words in every bank");

    for (int i = 0; i < 12; i++) begin
      seed = lcg(seed);
      addr = {22'd0, seed[27:20], 2'b00};
      seed = lcg(seed);
      send_write(addr, seed, seed[31:28]);
      wait_done();
      send_read(addr);
      wait_done();
    end
    close_test(3, "partial strobes merge bytes");

    send_write(32'd1024, 32'h1234_5678, 4'b1111);
    send_write(32'd1040, 32'hcafe_f00d, 4'b1111); // would alias word 0x10 if wrapped
    send_write(32'h8000_0010, 32'h0bad_beef, 4'b0110);
    wait_done();
    send_read(32'd1024);
    send_read(32'h8000_0010);
    send_read(32'h0000_0010);
    wait_done();
    close_test(4, "out-of-range access gives SLVERR");

    stall_mode = 1'b1;
    for (int i = 0; i < 10; i++) begin
      seed = lcg(seed);
      addr = {22'd0, seed[27:20], 2'b00};
      seed = lcg(seed);
      data = seed;
      if (i % 2 == 0) begin
        send_write(addr, data, seed[31:28]);
        send_read(addr); // presented while the B beat is still pending
      end else begin
        send_read(addr);
        send_write(addr, data, seed[31:28]);
      end
      wait_done();
    end
    stall_mode = 1'b0;
    close_test(5, "back-pressure holds beats and blocks requests");

    for (int i = 0; i < 3; i++) begin
      seed = lcg(seed);
      addr = {22'd0, seed[27:20], 2'b00};
      seed = lcg(seed);
      aw.addr  = addr;
      aw.prot  = 3'b000;
      w.data   = seed;
      w.strb   = 4'b1111;
      ar.addr  = addr;
      ar.prot  = 3'b000;
      aw_valid = 1'b1;
      w_valid  = 1'b1;
      ar_valid = 1'b1;
      accept_write(); // the write has to win
      accept_read();
      wait_done();
    end
    close_test(6, "write wins over a simultaneous read");

    if (exp_b_q.size() != 0 || exp_r_q.size() != 0) begin
      $display("%0d expected beats never arrived", exp_b_q.size() + exp_r_q.size());
      errors++;
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: axil_tcdm.f
hdl/axil_pkg.sv
hdl/tcdm_pkg.sv
hdl/tcdm_req_decode.sv
hdl/tcdm_bank_array.sv
hdl/tcdm_resp_collect.sv
hdl/axil_tcdm_top.sv
testbench/axil_tcdm_chk.sv
testbench/axil_tcdm_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the AXI4-Lite TCDM testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -j 0 --top-module axil_tcdm_tb -f axil_tcdm.f -o axil_tcdm_sim \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/axil_tcdm_sim > sim.log 2>&1 \
  || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "result: fail"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "result: no verdict in sim.log"; exit 1; }
echo "result: pass"
